/* sim.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/fetchUnit.sv
verilog/aluCompute.sv
verilog/dataMemory.sv
verilog/executeStage.sv
verilog/cpu.sv
verification/cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpuPkg.sv
      - verilog/controlUnit.sv
      - verilog/registerFile.sv
      - verilog/fetchUnit.sv
      - verilog/aluCompute.sv
      - verilog/dataMemory.sv
      - verilog/executeStage.sv
      - verilog/cpu.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/cpuTb.sv

/* verification/cpuTb.sv */
////////////////////////////////////////////////////////////////////////////
// CPU testbench
// Directed programs checked against an ISA model of the write trace
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpuTb;

  localparam int timeoutCycles  = 2000;  // Five programs, each under 300 cycles
  localparam int modelStepLimit = 400;

  // One register write as seen on the trace
  typedef struct packed {
    logic [15:0]     cyc;   // Cycles after reset release
    cpuPkg::regIdx_t dst;
    cpuPkg::word_t   data;
  } wrEvent_t;

  logic            clk;
  logic            rstN;
  logic            progWe;
  cpuPkg::word_t   progAddr;
  cpuPkg::word_t   progData;
  logic            hlt;
  cpuPkg::word_t   pc;
  logic            wbValid;
  cpuPkg::regIdx_t wbReg;
  cpuPkg::word_t   wbData;

  cpuPkg::word_t prog [`IMEM_WORDS];
  int            progLen;
  wrEvent_t      expQ [$];   // Model write trace
  int            haltStep;   // Instructions before HLT
  cpuPkg::word_t haltPc;
  int            testErrors;
  int            errors;
  int            failedTests;
  int            testCount;
  int            cycleCount;
  int            seed;

  cpu dut0 (
    .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .hlt(hlt), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding
  function automatic cpuPkg::word_t aluInstr(input logic [3:0] op, input logic [3:0] d,
                                             input logic [3:0] s, input logic [3:0] t);
    return {op, d, s, t};
  endfunction

  function automatic cpuPkg::word_t byteInstr(input logic [3:0] op, input logic [3:0] d,
                                              input logic [7:0] imm8);
    return {op, d, imm8};
  endfunction

  function automatic cpuPkg::word_t branchInstr(input logic [2:0] cond, input int off);
    return {`OP_B, cond, off[8:0]};  // Offset in instructions
  endfunction

  function automatic cpuPkg::word_t regBranchInstr(input logic [2:0] cond,
                                                   input logic [3:0] s);
    return {`OP_BR, cond, 1'b0, s, 4'h0};
  endfunction

  task automatic emit(input cpuPkg::word_t w);
    prog[progLen] = w;
    progLen++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // ISA reference model
  function automatic logic condHolds(input logic [2:0] cond, input logic z, input logic v,
                                     input logic n);
    case (cond)
      `BR_NE:  return !z;
      `BR_EQ:  return z;
      `BR_GT:  return !z && !n;
      `BR_LT:  return n;
      `BR_GE:  return z || !n;
      `BR_LE:  return n || z;
      `BR_OVF: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic isaModel();
    cpuPkg::word_t r [16];
    cpuPkg::word_t dmem [int];
    cpuPkg::word_t ins, a, b, res, addr, curPc, nextPc;
    logic [3:0]    op, d, s, t;
    logic          z, v, n, wr;
    int            i, step, sa, sb, wide, off;
    expQ.delete();
    for (i = 0; i < 16; i++)
      r[i] = '0;
    curPc = '0;
    z = 1'b0;
    v = 1'b0;
    n = 1'b0;
    haltStep = -1;
    for (step = 0; step < modelStepLimit && haltStep < 0; step++) begin
      ins = prog[(curPc >> 1) % `IMEM_WORDS];
      op = ins[15:12];
      d = ins[11:8];
      s = ins[7:4];
      t = ins[3:0];
      a = r[s];
      b = r[t];
      nextPc = curPc + 16'd2;
      wr = 1'b0;
      case (op)
        `OP_ADD, `OP_SUB: begin
          sa = $signed(a);
          sb = $signed(b);
          wide = (op == `OP_ADD) ? sa + sb : sa - sb;
          res = wide[15:0];                         // Wraps
          v = (wide > 32767) || (wide < -32768);   // Out of 16-bit signed range
          n = res[15];
          z = (res == 0);
          wr = 1'b1;
        end
        `OP_XOR, `OP_SLL, `OP_SRA, `OP_ROR: begin
          sa = $signed(a);
          if (op == `OP_XOR)
            res = a ^ b;
          else if (op == `OP_SLL)
            res = a << t;
          else if (op == `OP_SRA)
            res = sa >>> t;
          else
            res = (a >> t) | (a << (16 - t));
          z = (res == 0);  // V and N untouched
          wr = 1'b1;
        end
        `OP_LW, `OP_SW: begin
          off = $signed(t);
          addr = a + 16'(off * 2);
          if (op == `OP_SW) begin
            dmem[(addr >> 1) % `DMEM_WORDS] = r[d];  // Data from rd field
          end else begin
            res = dmem.exists((addr >> 1) % `DMEM_WORDS) ?
                  dmem[(addr >> 1) % `DMEM_WORDS] : 'x;
            wr = 1'b1;
          end
        end
        `OP_LLB: begin
          res = {r[d][15:8], ins[7:0]};
          wr = 1'b1;
        end
        `OP_LHB: begin
          res = {ins[7:0], r[d][7:0]};
          wr = 1'b1;
        end
        `OP_B: begin
          off = $signed(ins[8:0]);
          if (condHolds(ins[11:9], z, v, n))
            nextPc = curPc + 16'd2 + 16'(off * 2);
        end
        `OP_BR: if (condHolds(ins[11:9], z, v, n)) nextPc = a;
        `OP_PCS: begin
          res = curPc + 16'd2;
          wr = 1'b1;
        end
        `OP_HLT: begin
          haltStep = step;
          haltPc = curPc;
        end
        default: ;  // Reserved opcodes do nothing
      endcase
      if (wr) begin
        expQ.push_back({16'(step + 1), d, res});  // Trace one cycle after fetch
        if (d != 0)
          r[d] = res;
      end
      curPc = nextPc;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program load, run and trace compare
  task automatic valueError(input string name, input string what, input string expected,
                            input string actual);
    $display("** Error [%s] %s: expected %s, actual %s", name, what, expected, actual);
    testErrors++;
  endtask

  task automatic loadProgram();
    int i;
    @(posedge clk);
    rstN <= 1'b0;
    for (i = 0; i < progLen; i++) begin
      progWe   <= 1'b1;
      progAddr <= 16'(i * 2);
      progData <= prog[i];
      @(posedge clk);
    end
    progWe <= 1'b0;
    repeat (5) @(posedge clk);  // Reset stays low past the load
  endtask

  task automatic runProgram(input string name);
    wrEvent_t got, exp;
    int       c, hltCycle;
    logic     haltSeen;
    c = 0;
    hltCycle = 0;
    haltSeen = 1'b0;
    @(posedge clk);
    rstN <= 1'b1;
    // Until hlt plus a few quiet cycles, global watchdog covers a hang
    while (!(haltSeen && c > hltCycle + 3)) begin
      @(negedge clk);
      if (hlt !== (c > haltStep))
        valueError(name, $sformatf("hlt in cycle %0d", c), $sformatf("%0b", c > haltStep),
                   $sformatf("%b", hlt));
      if (hlt === 1'b1 && !haltSeen) begin
        haltSeen = 1'b1;
        hltCycle = c;
      end
      if (c >= haltStep && pc !== haltPc)
        valueError(name, $sformatf("pc in cycle %0d", c), $sformatf("%h", haltPc),
                   $sformatf("%h", pc));
      if (wbValid !== 1'b0) begin
        got = {16'(c), wbReg, wbData};
        if (expQ.size() == 0) begin
          $display("Test %s: unexpected register write in cycle %0d", name, c);
          testErrors++;
        end else begin
          exp = expQ.pop_front();
          if (got !== exp)
            valueError(name, "write",
                       $sformatf("cycle %0d r%0d=%h", exp.cyc, exp.dst, exp.data),
                       $sformatf("cycle %0d r%0d=%h", got.cyc, got.dst, got.data));
        end
      end
      c++;
    end
    if (expQ.size() != 0) begin
      $display("Test %s: %0d expected register writes never appeared", name, expQ.size());
      testErrors++;
    end
  endtask

  task automatic checkProgram(input string name);
    int nWrites;
    testErrors = 0;
    isaModel();
    nWrites = expQ.size();
    if (haltStep < 0) begin
      $display("Test %s: reference model never reached HLT", name);
      testErrors++;
    end else begin
      loadProgram();
      runProgram(name);
    end
    testCount++;
    errors += testErrors;
    if (testErrors == 0) begin
      $display("Test %-8s ok, %0d instructions, %0d writes", name, haltStep, nWrites);
    end else begin
      failedTests++;
      $display("Test %-8s failed with %0d errors", name, testErrors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  task automatic aluOpsTest();
    progLen = 0;
    emit(byteInstr(`OP_LLB, 1, 8'hFF));   // r1 = 00FF
    emit(byteInstr(`OP_LHB, 1, 8'h7F));   // r1 = 7FFF
    emit(byteInstr(`OP_LLB, 2, 8'h01));
    emit(aluInstr(`OP_ADD, 3, 1, 2));     // Wraps to 8000
    emit(aluInstr(`OP_SUB, 4, 3, 2));     // Wraps back to 7FFF
    emit(aluInstr(`OP_XOR, 5, 1, 3));
    emit(aluInstr(`OP_SLL, 6, 5, 4));
    emit(aluInstr(`OP_SRA, 7, 3, 3));     // Sign fill
    emit(aluInstr(`OP_ROR, 8, 1, 4));
    emit(aluInstr(4'h3, 9, 1, 2));        // Reserved, no write
    emit(aluInstr(`OP_SRA, 9, 1, 15));
    emit(aluInstr(`OP_ROR, 10, 2, 0));
    emit(aluInstr(`OP_HLT, 0, 0, 0));
    checkProgram("aluOps");
  endtask

  task automatic memoryTest();
    progLen = 0;
    emit(byteInstr(`OP_LLB, 1, 8'h40));   // Base 0040
    emit(byteInstr(`OP_LLB, 2, 8'h34));
    emit(byteInstr(`OP_LHB, 2, 8'h12));
    emit(byteInstr(`OP_LLB, 3, 8'hCD));
    emit(byteInstr(`OP_LHB, 3, 8'hAB));
    emit(aluInstr(`OP_ADD, 4, 2, 3));
    emit(aluInstr(`OP_SW, 2, 1, 0));
    emit(aluInstr(`OP_SW, 3, 1, 7));
    emit(aluInstr(`OP_SW, 4, 1, 4'hF));   // Offset -1
    emit(aluInstr(`OP_SW, 1, 1, 4'h8));   // Offset -8
    emit(aluInstr(`OP_LW, 5, 1, 0));
    emit(aluInstr(`OP_LW, 6, 1, 7));
    emit(aluInstr(`OP_LW, 7, 1, 4'hF));
    emit(aluInstr(`OP_LW, 8, 1, 4'h8));
    emit(aluInstr(`OP_SW, 5, 1, 1));      // Store then load right behind
    emit(aluInstr(`OP_LW, 9, 1, 1));
    emit(aluInstr(`OP_HLT, 0, 0, 0));
    checkProgram("memory");
  endtask

  task automatic branchTest();
    int fl, cond;
    progLen = 0;
    emit(byteInstr(`OP_LLB, 1, 8'h01));
    emit(byteInstr(`OP_LLB, 2, 8'h02));
    emit(byteInstr(`OP_LLB, 4, 8'hFF));
    emit(byteInstr(`OP_LHB, 4, 8'h7F));
    // Every condition after zero, negative, positive and overflow results
    for (fl = 0; fl < 4; fl++) begin
      for (cond = 0; cond < 8; cond++) begin
        case (fl)
          0:       emit(aluInstr(`OP_SUB, 3, 1, 1));
          1:       emit(aluInstr(`OP_SUB, 3, 1, 2));
          2:       emit(aluInstr(`OP_SUB, 3, 2, 1));
          default: emit(aluInstr(`OP_ADD, 3, 4, 1));  // V and N set
        endcase
        emit(branchInstr(3'(cond), 1));                // Skips marker when taken
        emit(byteInstr(`OP_LLB, 5, 8'(fl * 8 + cond)));
      end
    end
    // BR on a register written just before
    emit(aluInstr(`OP_SUB, 3, 1, 1));
    emit(byteInstr(`OP_LLB, 6, 8'((progLen + 4) * 2)));
    emit(regBranchInstr(`BR_EQ, 6));
    emit(byteInstr(`OP_LLB, 7, 8'hAA));
    emit(byteInstr(`OP_LLB, 7, 8'hBB));
    emit(regBranchInstr(`BR_NE, 6));  // Z still set, falls through
    emit(byteInstr(`OP_LLB, 7, 8'hCC));
    emit(aluInstr(`OP_HLT, 0, 0, 0));
    checkProgram("branch");
  endtask

  task automatic bypassTest();
    progLen = 0;
    emit(byteInstr(`OP_LLB, 1, 8'h03));
    emit(byteInstr(`OP_LLB, 2, 8'h01));
    emit(aluInstr(`OP_ADD, 3, 1, 2));
    emit(aluInstr(`OP_ADD, 4, 3, 3));
    emit(aluInstr(`OP_XOR, 5, 4, 1));
    emit(aluInstr(`OP_SLL, 6, 5, 2));
    emit(aluInstr(`OP_ADD, 6, 6, 6));
    emit(aluInstr(`OP_SUB, 1, 1, 2));  // Count down loop
    emit(branchInstr(`BR_NE, -2));     // Backward, flags from SUB
    emit(aluInstr(`OP_PCS, 7, 0, 0));
    emit(aluInstr(`OP_SW, 6, 0, 0));
    emit(aluInstr(`OP_LW, 8, 0, 0));
    emit(aluInstr(`OP_ADD, 9, 8, 8));
    emit(aluInstr(`OP_ADD, 10, 0, 9));  // r0 reads zero
    emit(aluInstr(`OP_HLT, 0, 0, 0));
    checkProgram("bypass");
  endtask

  task automatic randomTest();
    logic [3:0] ops [6];
    logic [3:0] op, d, s, t;
    int         i;
    ops = '{`OP_ADD, `OP_SUB, `OP_XOR, `OP_SLL, `OP_SRA, `OP_ROR};
    progLen = 0;
    for (i = 1; i < 9; i++) begin
      emit(byteInstr(`OP_LLB, 4'(i), 8'($random(seed))));
      emit(byteInstr(`OP_LHB, 4'(i), 8'($random(seed))));
    end
    for (i = 0; i < 40; i++) begin
      op = ops[$unsigned($random(seed)) % 6];
      d = 4'(1 + $unsigned($random(seed)) % 15);  // Never r0
      s = 4'($random(seed));
      t = 4'($random(seed));
      emit(aluInstr(op, d, s, t));
    end
    emit(aluInstr(`OP_HLT, 0, 0, 0));
    checkProgram("random");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  initial begin
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    seed = 15;
    errors = 0;
    failedTests = 0;
    testCount = 0;
    repeat (5) @(posedge clk);  // Power-on reset
    aluOpsTest();
    memoryTest();
    branchTest();
    bypassTest();
    randomTest();
    $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errors);
    if (errors == 0 && failedTests == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run not finished after %0d cycles, a program never halted",
             timeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog/cpu.sv */
////////////////////////////////////////////////////////////////////////////
// CPU top
// Two-stage 16-bit core: fetch/decode/branch, then execute/memory/write-back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module cpu (
  input  logic            clk,
  input  logic            rstN,
  input  logic            progWe,
  input  cpuPkg::word_t   progAddr,
  input  cpuPkg::word_t   progData,
  output logic            hlt,
  output cpuPkg::word_t   pc,
  output logic            wbValid,   // Register write trace
  output cpuPkg::regIdx_t wbReg,
  output cpuPkg::word_t   wbData
);

  cpuPkg::word_t   instr, pcPlus2, imm;
  cpuPkg::word_t   srcData1, srcData2;
  cpuPkg::regIdx_t rs, rt, rd;
  cpuPkg::ctrl_t   ctrl;
  cpuPkg::flags_t  flagsNext;
  cpuPkg::issue_t  issue;
  cpuPkg::wb_t     wb;

  //////////////////////////////////////////////////////////////////////////
  // Stage one
  fetchUnit fetch0 (
    .clk(clk), .rstN(rstN),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .srcData1(srcData1), .flagsNext(flagsNext), .ctrl(ctrl),
    .instr(instr), .pc(pc), .pcPlus2(pcPlus2)
  );

  controlUnit ctrl0 (
    .instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .rd(rd), .imm(imm)
  );

  registerFile regs0 (
    .clk(clk), .rstN(rstN), .rs(rs), .rt(rt), .wb(wb),
    .srcData1(srcData1), .srcData2(srcData2)
  );

  always_comb begin
    issue.valid   = !ctrl.isHlt && (ctrl != '0);  // Reserved ops decode empty
    issue.opcode  = instr[15:12];
    issue.ctrl    = ctrl;
    issue.dstReg  = ctrl.dstRegSel ? rd : rt;
    issue.srcA    = srcData1;
    issue.srcB    = srcData2;
    issue.imm     = imm;
    issue.pcPlus2 = pcPlus2;
  end

  //////////////////////////////////////////////////////////////////////////
  // Stage two
  executeStage exec0 (
    .clk(clk), .rstN(rstN), .issueIn(issue),
    .wb(wb), .flagsNext(flagsNext), .hlt(hlt)
  );

  assign wbValid = wb.valid;
  assign wbReg   = wb.dstReg;
  assign wbData  = wb.data;

  // Once halted, PC frozen and no more writes
  assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc) && !wbValid)
    else $error("activity after hlt");

endmodule

/* verilog/executeStage.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage
// Issue and flag registers, ALU and data memory, write-back select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module executeStage (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::issue_t issueIn,
  output cpuPkg::wb_t    wb,
  output cpuPkg::flags_t flagsNext,  // Bypass to branch check
  output logic           hlt
);

  cpuPkg::issue_t issueQ;
  cpuPkg::flags_t flagsQ;
  cpuPkg::word_t  aluResult;
  cpuPkg::word_t  memRdData;

  //////////////////////////////////////////////////////////////////////////
  // Pipeline registers
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issueQ <= '0;
      flagsQ <= '0;
      hlt    <= 1'b0;
    end else begin
      issueQ <= issueIn;
      flagsQ <= flagsNext;
      hlt    <= hlt | issueIn.ctrl.isHlt;  // Sticky until reset
    end
  end

  aluCompute alu0 (
    .issue     (issueQ),
    .flags     (flagsQ),
    .result    (aluResult),
    .flagsNext (flagsNext)
  );

  dataMemory dmem0 (
    .clk    (clk),
    .addr   (aluResult),
    .wrData (issueQ.srcB),  // SW data
    .wrEn   (issueQ.valid && issueQ.ctrl.memWr),
    .rdData (memRdData)
  );

  //////////////////////////////////////////////////////////////////////////
  // Write-back select
  always_comb begin
    wb.valid  = issueQ.valid && issueQ.ctrl.regWrEn;
    wb.dstReg = issueQ.dstReg;
    if (issueQ.ctrl.memToReg)
      wb.data = memRdData;         // LW
    else if (issueQ.ctrl.isPcs)
      wb.data = issueQ.pcPlus2;    // PCS
    else
      wb.data = aluResult;         // Incl. LLB/LHB merge
  end

endmodule

/* verilog/dataMemory.sv */
////////////////////////////////////////////////////////////////////////////
// Data memory
// Word RAM, combinational read, write on the clock edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cpu_defs.svh"

module dataMemory (
  input  logic          clk,
  input  cpuPkg::word_t addr,    // Byte address, bit 0 ignored
  input  cpuPkg::word_t wrData,
  input  logic          wrEn,
  output cpuPkg::word_t rdData
);

  localparam int dmemIdxW = $clog2(`DMEM_WORDS);

  cpuPkg::word_t mem [`DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (wrEn)
      mem[addr[dmemIdxW:1]] <= wrData;
  end

  assign rdData = mem[addr[dmemIdxW:1]];

endmodule

/* verilog/aluCompute.sv */
////////////////////////////////////////////////////////////////////////////
// ALU
// Result and next flag value for the instruction in stage two
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cpu_defs.svh"

module aluCompute (
  input  cpuPkg::issue_t issue,
  input  cpuPkg::flags_t flags,      // Current flag register
  output cpuPkg::word_t  result,
  output cpuPkg::flags_t flagsNext
);

  cpuPkg::word_t opA, opB;
  cpuPkg::word_t sum, diff;
  cpuPkg::word_t memOff;    // Sign-extended nibble * 2
  logic [31:0]   rotTmp;
  logic [3:0]    shAmt;
  logic          ovf;

  assign opA    = issue.srcA;
  assign opB    = issue.ctrl.aluSrc ? issue.imm : issue.srcB;
  assign shAmt  = opB[3:0];
  assign sum    = opA + opB;   // Wraps
  assign diff   = opA - opB;
  assign memOff = {{11{issue.imm[3]}}, issue.imm[3:0], 1'b0};
  assign rotTmp = {opA, opA} >> shAmt;

  always_comb begin
    ovf = 1'b0;
    case (issue.opcode)
      `OP_ADD: begin
        result = sum;
        ovf    = (opA[15] == opB[15]) && (sum[15] != opA[15]);
      end
      `OP_SUB: begin
        result = diff;
        ovf    = (opA[15] != opB[15]) && (diff[15] != opA[15]);
      end
      `OP_XOR: result = opA ^ opB;
      `OP_SLL: result = opA << shAmt;
      `OP_SRA: result = $signed(opA) >>> shAmt;
      `OP_ROR: result = rotTmp[15:0];
      `OP_LW, `OP_SW: result = opA + memOff;  // Data address
      `OP_LLB: result = {opA[15:8], issue.imm[7:0]};
      `OP_LHB: result = {issue.imm[7:0], opA[7:0]};
      default: result = '0;
    endcase
  end

  // Only the bits the instruction owns change
  always_comb begin
    flagsNext = flags;
    if (issue.valid && issue.ctrl.setsZ)
      flagsNext[`FLAG_Z] = (result == '0);
    if (issue.valid && issue.ctrl.setsVN) begin
      flagsNext[`FLAG_V] = ovf;
      flagsNext[`FLAG_N] = result[15];
    end
  end

endmodule

/* verilog/fetchUnit.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch unit
// PC, loadable instruction memory, branch resolution and next-PC select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetchUnit (
  input  logic           clk,
  input  logic           rstN,
  input  logic           progWe,     // Program load strobe, reset only
  input  cpuPkg::word_t  progAddr,   // Byte address, bit 0 ignored
  input  cpuPkg::word_t  progData,
  input  cpuPkg::word_t  srcData1,   // BR target register
  input  cpuPkg::flags_t flagsNext,  // Flags after stage-two instruction
  input  cpuPkg::ctrl_t  ctrl,
  output cpuPkg::word_t  instr,
  output cpuPkg::word_t  pc,
  output cpuPkg::word_t  pcPlus2
);

  localparam int imemIdxW = $clog2(`IMEM_WORDS);

  cpuPkg::word_t imem [`IMEM_WORDS];
  cpuPkg::word_t bTarget;   // PC+2 + offset*2
  cpuPkg::word_t nextPc;
  logic          condPass;
  logic          flagZ, flagV, flagN;

  // Program port, no reset on contents
  always_ff @(posedge clk) begin
    if (progWe)
      imem[progAddr[imemIdxW:1]] <= progData;
  end

  assign instr   = imem[pc[imemIdxW:1]];  // Combinational read
  assign pcPlus2 = pc + cpuPkg::word_t'(2);

  //////////////////////////////////////////////////////////////////////////
  // Branch condition against bypassed flags
  assign flagZ = flagsNext[`FLAG_Z];
  assign flagV = flagsNext[`FLAG_V];
  assign flagN = flagsNext[`FLAG_N];

  always_comb begin
    case (instr[11:9])
      `BR_NE:  condPass = !flagZ;
      `BR_EQ:  condPass = flagZ;
      `BR_GT:  condPass = !flagZ && !flagN;
      `BR_LT:  condPass = flagN;
      `BR_GE:  condPass = flagZ || !flagN;
      `BR_LE:  condPass = flagN || flagZ;
      `BR_OVF: condPass = flagV;
      default: condPass = 1'b1;  // UNC
    endcase
  end

  assign bTarget = pcPlus2 + {{6{instr[8]}}, instr[8:0], 1'b0};

  //////////////////////////////////////////////////////////////////////////
  // Next PC
  always_comb begin
    if (ctrl.isHlt)
      nextPc = pc;  // Hold on HLT
    else if (ctrl.branch && condPass)
      nextPc = (instr[15:12] == `OP_BR) ? srcData1 : bTarget;
    else
      nextPc = pcPlus2;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      pc <= '0;
    else
      pc <= nextPc;
  end

  // Loading only allowed in reset
  assert property (@(posedge clk) rstN |-> !progWe)
    else $error("progWe high outside reset");

endmodule

/* verilog/registerFile.sv */
////////////////////////////////////////////////////////////////////////////
// Register file
// 16 x 16 bits, two read ports, one write port, write-through bypass
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module registerFile (
  input  logic            clk,
  input  logic            rstN,
  input  cpuPkg::regIdx_t rs,
  input  cpuPkg::regIdx_t rt,
  input  cpuPkg::wb_t     wb,
  output cpuPkg::word_t   srcData1,
  output cpuPkg::word_t   srcData2
);

  cpuPkg::word_t regs [16];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end else if (wb.valid && wb.dstReg != '0) begin
      regs[wb.dstReg] <= wb.data;
    end
  end

  // Same-cycle write wins over stored value
  // r0 always reads zero
  assign srcData1 = (rs == '0) ? '0 :
                    (wb.valid && wb.dstReg == rs) ? wb.data : regs[rs];
  assign srcData2 = (rt == '0) ? '0 :
                    (wb.valid && wb.dstReg == rt) ? wb.data : regs[rt];

endmodule

/* verilog/controlUnit.sv */
////////////////////////////////////////////////////////////////////////////
// Control unit
// Decodes an instruction into register indices, immediate and control bits
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "cpu_defs.svh"

module controlUnit (
  input  cpuPkg::word_t   instr,
  output cpuPkg::ctrl_t   ctrl,
  output cpuPkg::regIdx_t rs,
  output cpuPkg::regIdx_t rt,
  output cpuPkg::regIdx_t rd,
  output cpuPkg::word_t   imm
);

  logic [3:0] opcode;
  logic       isByteLoad;  // LLB or LHB

  assign opcode     = instr[15:12];
  assign isByteLoad = (opcode == `OP_LLB) || (opcode == `OP_LHB);

  // Register fields
  assign rd = instr[11:8];
  assign rs = isByteLoad ? instr[11:8] : instr[7:4];  // Old value for byte merge
  assign rt = (opcode == `OP_SW) ? instr[11:8] : instr[3:0];  // SW data in rd field

  // 8-bit signed for byte loads, else low nibble (shift or offset)
  assign imm = isByteLoad ? {{8{instr[7]}}, instr[7:0]} : {12'd0, instr[3:0]};

  always_comb begin
    ctrl = '0;  // Reserved opcodes stay empty
    case (opcode)
      `OP_ADD, `OP_SUB: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.setsZ     = 1'b1;
        ctrl.setsVN    = 1'b1;
      end
      `OP_XOR: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.setsZ     = 1'b1;
      end
      `OP_SLL, `OP_SRA, `OP_ROR: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.aluSrc    = 1'b1;  // Shift amount
        ctrl.setsZ     = 1'b1;
      end
      `OP_LW: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.aluSrc    = 1'b1;
        ctrl.memToReg  = 1'b1;
      end
      `OP_SW: begin
        ctrl.aluSrc = 1'b1;
        ctrl.memWr  = 1'b1;
      end
      `OP_LLB, `OP_LHB: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.aluSrc    = 1'b1;
      end
      `OP_B, `OP_BR: ctrl.branch = 1'b1;
      `OP_PCS: begin
        ctrl.regWrEn   = 1'b1;
        ctrl.dstRegSel = 1'b1;
        ctrl.isPcs     = 1'b1;
      end
      `OP_HLT: ctrl.isHlt = 1'b1;
      default: ;
    endcase
  end

endmodule

/* verilog/cpuPkg.sv */
////////////////////////////////////////////////////////////////////////////
// CPU package
// Word, index and flag types plus control and pipeline structs
////////////////////////////////////////////////////////////////////////////
package cpuPkg;

  typedef logic [15:0] word_t;    // Data, address, instruction
  typedef logic [3:0]  regIdx_t;  // One of 16 registers
  typedef logic [2:0]  flags_t;   // {Z, V, N}

  // Decoded control bits
  typedef struct packed {
    logic regWrEn;    // Writes a register
    logic memToReg;   // LW
    logic memWr;      // SW
    logic aluSrc;     // Immediate as ALU B input
    logic dstRegSel;  // Destination is rd field
    logic branch;     // B or BR
    logic setsZ;      // Updates Z
    logic setsVN;     // Updates V and N
    logic isPcs;      // Write-back of PC+2
    logic isHlt;
  } ctrl_t;

  // Stage one to stage two
  typedef struct packed {
    logic    valid;    // Low for HLT and no-ops
    logic [3:0] opcode;
    ctrl_t   ctrl;
    regIdx_t dstReg;
    word_t   srcA;     // Read data after write-through
    word_t   srcB;
    word_t   imm;
    word_t   pcPlus2;
  } issue_t;

  // Register write-back
  typedef struct packed {
    logic    valid;
    regIdx_t dstReg;
    word_t   data;
  } wb_t;

endpackage

/* verilog/cpu_defs.svh */
////////////////////////////////////////////////////////////////////////////
// CPU definitions
// Opcodes, branch condition codes, flag bit positions and memory depths
////////////////////////////////////////////////////////////////////////////
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Opcodes, instr[15:12]
`define OP_ADD 4'h0
`define OP_SUB 4'h1
`define OP_XOR 4'h2
`define OP_SLL 4'h4
`define OP_SRA 4'h5
`define OP_ROR 4'h6
`define OP_LW  4'h8
`define OP_SW  4'h9
`define OP_LLB 4'hA
`define OP_LHB 4'hB
`define OP_B   4'hC
`define OP_BR  4'hD
`define OP_PCS 4'hE
`define OP_HLT 4'hF

// Branch conditions, instr[11:9]
`define BR_NE  3'd0  // Z clear
`define BR_EQ  3'd1  // Z set
`define BR_GT  3'd2  // Z and N clear
`define BR_LT  3'd3  // N set
`define BR_GE  3'd4  // Z set or N clear
`define BR_LE  3'd5  // N or Z set
`define BR_OVF 3'd6  // V set
`define BR_UNC 3'd7  // Always

// Bit positions inside flags_t
`define FLAG_Z 2
`define FLAG_V 1
`define FLAG_N 0

// Memory depths in words, powers of two
`define IMEM_WORDS 256
`define DMEM_WORDS 256

`endif
